// File: gfx_config.svh
`ifndef GFX_CONFIG_SVH
`define GFX_CONFIG_SVH

// Register file size, addresses 0 to 95
`define GFX_REG_COUNT     96

// Interrupt enables and flip
`define GFX_REG_CTRL      7
`define GFX_BIT_NMI_EN    0
`define GFX_BIT_IRQ_EN    1
`define GFX_BIT_FLIP      3

// Object page select
`define GFX_REG_PAGE      3
`define GFX_BIT_OBJ_PAGE  3

// Video RAM address widths
`define GFX_TILE_AW       11
`define GFX_OBJ_AW        12

// Low six bits of vdump where NMI fires
// Held while vdump bits 5:4 are both set
`define GFX_NMI_LINE      48

`endif

// File: gfx_pkg.sv
`include "gfx_config.svh"

package gfx_pkg;

    // CPU data bus and register contents
    typedef logic [7:0]                 byte_t;

    // Address inside the chip as seen by the CPU
    typedef logic [13:0]                cpu_addr_t;

    // Vertical dump counter
    typedef logic [8:0]                 vpos_t;

    // Video RAM addresses
    typedef logic [`GFX_TILE_AW-1:0]    tile_addr_t;
    typedef logic [`GFX_OBJ_AW-1:0]     obj_addr_t;
    typedef logic [9:0]                 obj_scan_t;

    // Graphics ROM word port
    typedef logic [17:0]                rom_addr_t;
    typedef logic [15:0]                rom_data_t;

    // Current owner of the ROM port
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_SCR,
        ARB_OBJ
    } arb_owner_t;

endpackage

// File: gfx_regs.sv
`timescale 1ns/1ps
`include "gfx_config.svh"

module gfx_regs (
    input  logic              clk,
    input  logic              rst,
    input  logic              cs,
    input  logic              cpu_rnw,
    input  logic              cpu_cen,
    input  gfx_pkg::cpu_addr_t addr,
    input  gfx_pkg::byte_t    cpu_dout,
    input  gfx_pkg::byte_t    attr_dout,
    input  gfx_pkg::byte_t    code_dout,
    input  gfx_pkg::byte_t    obj_dout,
    output gfx_pkg::byte_t    dout,
    output logic              attr_we,
    output logic              code_we,
    output logic              obj_we,
    output logic              flip,
    output logic              irq_en,
    output logic              nmi_en,
    output logic              obj_page
);

    // Registers 0..7 reset to zero, 8..23 to all ones
    localparam int ZERO_COUNT = 8;
    localparam int CTL_COUNT  = 24;

    gfx_pkg::byte_t ctl_regs [0:CTL_COUNT-1];
    gfx_pkg::byte_t ext_regs [CTL_COUNT:`GFX_REG_COUNT-1];

    logic       cpu_wr;
    logic       reg_space;
    logic       reg_we;
    logic [6:0] reg_idx;
    logic       reg_is_ctl;

    assign cpu_wr     = cs & cpu_cen & ~cpu_rnw;
    assign reg_space  = addr < gfx_pkg::cpu_addr_t'(`GFX_REG_COUNT);
    assign reg_idx    = addr[6:0];
    assign reg_is_ctl = reg_idx < 7'(CTL_COUNT);
    assign reg_we     = cpu_wr & reg_space;

    // RAM space is bit 13, bit 12 picks objects, bit 10 code over attributes
    assign attr_we = cpu_wr & addr[13] & ~addr[12] & ~addr[10];
    assign code_we = cpu_wr & addr[13] & ~addr[12] &  addr[10];
    assign obj_we  = cpu_wr & addr[13] &  addr[12];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < CTL_COUNT; i++) begin
                ctl_regs[i] <= (i < ZERO_COUNT) ? 8'h00 : 8'hff;
            end
        end else if (reg_we && reg_is_ctl) begin
            ctl_regs[reg_idx[4:0]] <= cpu_dout;
        end
    end

    // Upper registers keep whatever power-up left in them
    always_ff @(posedge clk) begin
        if (reg_we && !reg_is_ctl) begin
            ext_regs[reg_idx] <= cpu_dout;
        end
    end

    always_comb begin
        if (addr[13]) begin
            dout = addr[12] ? obj_dout : (addr[10] ? code_dout : attr_dout);
        end else if (!reg_space) begin
            dout = '0;
        end else if (reg_is_ctl) begin
            dout = ctl_regs[reg_idx[4:0]];
        end else begin
            dout = ext_regs[reg_idx];
        end
    end

    assign nmi_en   = ctl_regs[`GFX_REG_CTRL][`GFX_BIT_NMI_EN];
    assign irq_en   = ctl_regs[`GFX_REG_CTRL][`GFX_BIT_IRQ_EN];
    assign flip     = ctl_regs[`GFX_REG_CTRL][`GFX_BIT_FLIP];
    assign obj_page = ctl_regs[`GFX_REG_PAGE][`GFX_BIT_OBJ_PAGE];

endmodule

// File: gfx_vram.sv
`timescale 1ns/1ps

module gfx_vram #(
    parameter int aw = 11
) (
    input  logic          clk,
    input  logic          we,
    input  logic [aw-1:0] cpu_addr,
    input  logic [7:0]    cpu_din,
    input  logic [aw-1:0] scan_addr,
    output logic [7:0]    cpu_q,
    output logic [7:0]    scan_q
);

    logic [7:0] mem [0:(1<<aw)-1];

    // CPU port, read returns the old contents on a write cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[cpu_addr] <= cpu_din;
        end
        cpu_q <= mem[cpu_addr];
    end

    // Scan port is read only
    always_ff @(posedge clk) begin
        scan_q <= mem[scan_addr];
    end

endmodule

// File: gfx_irq.sv
`timescale 1ns/1ps
`include "gfx_config.svh"

module gfx_irq (
    input  logic          clk,
    input  logic          rst,
    input  logic          pxl_cen,
    input  logic          LVBL,
    input  logic          LHBL,
    input  logic          irq_en,
    input  logic          nmi_en,
    input  gfx_pkg::vpos_t vdump,
    output logic          cpu_irqn,
    output logic          cpu_nmin
);

    logic last_lvbl;
    logic vblank_fall;
    logic nmi_line;
    logic nmi_window;

    assign vblank_fall = last_lvbl & ~LVBL;
    assign nmi_line    = vdump[5:0] == 6'(`GFX_NMI_LINE);
    assign nmi_window  = vdump[5:4] == 2'b11;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_lvbl <= 1'b0;
            cpu_irqn  <= 1'b1;
            cpu_nmin  <= 1'b1;
        end else if (pxl_cen) begin
            last_lvbl <= LVBL;

            // IRQ once per frame at the start of vertical blank
            if (vblank_fall) begin
                if (irq_en) begin
                    cpu_irqn <= 1'b0;
                end
            end else if (LHBL || !irq_en) begin
                cpu_irqn <= 1'b1;
            end

            // NMI held through the rest of the 16-line window
            if (!nmi_en || !nmi_window) begin
                cpu_nmin <= 1'b1;
            end else if (nmi_line) begin
                cpu_nmin <= 1'b0;
            end
        end
    end

endmodule

// File: gfx_rom_arbiter.sv
`timescale 1ns/1ps

module gfx_rom_arbiter (
    input  logic               clk,
    input  logic               rst,
    input  logic [1:0]         gfx_en,
    input  logic               scr_cs,
    input  logic               obj_cs,
    input  gfx_pkg::rom_addr_t scr_addr,
    input  gfx_pkg::rom_addr_t obj_addr,
    input  gfx_pkg::rom_data_t rom_data,
    input  logic               rom_ok,
    output gfx_pkg::rom_data_t scr_data,
    output gfx_pkg::rom_data_t obj_data,
    output logic               scr_ok,
    output logic               obj_ok,
    output logic               rom_cs,
    output logic               rom_obj_sel,
    output gfx_pkg::rom_addr_t rom_addr
);

    gfx_pkg::arb_owner_t owner;

    // Low in the first cycle of an access while rom_ok may still be stale
    logic settled;
    logic last_scr_cs;
    logic last_obj_cs;
    logic done;

    assign done = (owner != gfx_pkg::ARB_IDLE) && settled && rom_ok;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            owner       <= gfx_pkg::ARB_IDLE;
            settled     <= 1'b0;
            rom_cs      <= 1'b0;
            rom_obj_sel <= 1'b0;
            rom_addr    <= '0;
            scr_ok      <= 1'b0;
            obj_ok      <= 1'b0;
            last_scr_cs <= 1'b0;
            last_obj_cs <= 1'b0;
        end else begin
            last_scr_cs <= scr_cs;
            last_obj_cs <= obj_cs;
            // New request from a client invalidates its previous result
            if (scr_cs && !last_scr_cs) begin
                scr_ok <= 1'b0;
            end
            if (obj_cs && !last_obj_cs) begin
                obj_ok <= 1'b0;
            end

            if (owner == gfx_pkg::ARB_IDLE) begin
                settled <= 1'b0;
                // Scroll layer has priority
                if (scr_cs && gfx_en[0]) begin
                    owner       <= gfx_pkg::ARB_SCR;
                    rom_cs      <= 1'b1;
                    rom_addr    <= scr_addr;
                    rom_obj_sel <= 1'b0;
                    scr_ok      <= 1'b0;
                end else if (obj_cs && gfx_en[1]) begin
                    owner       <= gfx_pkg::ARB_OBJ;
                    rom_cs      <= 1'b1;
                    rom_addr    <= obj_addr;
                    rom_obj_sel <= 1'b1;
                    obj_ok      <= 1'b0;
                end
            end else if (done) begin
                // Disabled clients are released along with the owner
                if (owner == gfx_pkg::ARB_SCR || !gfx_en[0]) begin
                    scr_ok <= 1'b1;
                end
                if (owner == gfx_pkg::ARB_OBJ || !gfx_en[1]) begin
                    obj_ok <= 1'b1;
                end
                owner       <= gfx_pkg::ARB_IDLE;
                rom_cs      <= 1'b0;
                rom_obj_sel <= 1'b0;
            end else begin
                settled <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            if (owner == gfx_pkg::ARB_SCR) begin
                scr_data <= rom_data;
            end else if (!gfx_en[0]) begin
                scr_data <= '0;
            end
            if (owner == gfx_pkg::ARB_OBJ) begin
                obj_data <= rom_data;
            end else if (!gfx_en[1]) begin
                obj_data <= '0;
            end
        end
    end

endmodule

// File: gfx_top.sv
`timescale 1ns/1ps

module gfx_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                pxl_cen,
    input  logic                LHBL,
    input  logic                LVBL,
    input  gfx_pkg::vpos_t      vdump,
    input  logic                cs,
    input  logic                cpu_rnw,
    input  logic                cpu_cen,
    input  gfx_pkg::cpu_addr_t  addr,
    input  gfx_pkg::byte_t      cpu_dout,
    input  gfx_pkg::tile_addr_t tile_scan_addr,
    input  gfx_pkg::obj_scan_t  obj_scan_addr,
    input  logic [1:0]          gfx_en,
    input  logic                scr_cs,
    input  logic                obj_cs,
    input  gfx_pkg::rom_addr_t  scr_addr,
    input  gfx_pkg::rom_addr_t  obj_addr,
    input  gfx_pkg::rom_data_t  rom_data,
    input  logic                rom_ok,
    output gfx_pkg::byte_t      dout,
    output logic                cpu_irqn,
    output logic                cpu_nmin,
    output logic                flip,
    output gfx_pkg::byte_t      attr_scan,
    output gfx_pkg::byte_t      code_scan,
    output gfx_pkg::byte_t      obj_scan,
    output gfx_pkg::rom_data_t  scr_data,
    output gfx_pkg::rom_data_t  obj_data,
    output logic                scr_ok,
    output logic                obj_ok,
    output logic                rom_cs,
    output logic                rom_obj_sel,
    output gfx_pkg::rom_addr_t  rom_addr
);

    gfx_pkg::byte_t      attr_dout;
    gfx_pkg::byte_t      code_dout;
    gfx_pkg::byte_t      obj_dout;
    logic                attr_we;
    logic                code_we;
    logic                obj_we;
    logic                irq_en;
    logic                nmi_en;
    logic                obj_page;
    gfx_pkg::tile_addr_t tile_cpu_addr;
    gfx_pkg::obj_addr_t  obj_cpu_addr;
    gfx_pkg::obj_addr_t  obj_ram_scan;

    // Bit 10 is the code/attribute select, so it is skipped here
    assign tile_cpu_addr = {addr[11], addr[9:0]};
    assign obj_cpu_addr  = addr[11:0];
    // Scanner only sees the lower half of the selected page
    assign obj_ram_scan  = {obj_page, 1'b0, obj_scan_addr};

    gfx_regs u_regs (
        .clk(clk), .rst(rst), .cs(cs), .cpu_rnw(cpu_rnw), .cpu_cen(cpu_cen),
        .addr(addr), .cpu_dout(cpu_dout), .attr_dout(attr_dout),
        .code_dout(code_dout), .obj_dout(obj_dout), .dout(dout),
        .attr_we(attr_we), .code_we(code_we), .obj_we(obj_we), .flip(flip),
        .irq_en(irq_en), .nmi_en(nmi_en), .obj_page(obj_page)
    );

    gfx_vram #(.aw(11)) u_attr_ram (
        .clk(clk), .we(attr_we), .cpu_addr(tile_cpu_addr), .cpu_din(cpu_dout),
        .scan_addr(tile_scan_addr), .cpu_q(attr_dout), .scan_q(attr_scan)
    );

    gfx_vram #(.aw(11)) u_code_ram (
        .clk(clk), .we(code_we), .cpu_addr(tile_cpu_addr), .cpu_din(cpu_dout),
        .scan_addr(tile_scan_addr), .cpu_q(code_dout), .scan_q(code_scan)
    );

    gfx_vram #(.aw(12)) u_obj_ram (
        .clk(clk), .we(obj_we), .cpu_addr(obj_cpu_addr), .cpu_din(cpu_dout),
        .scan_addr(obj_ram_scan), .cpu_q(obj_dout), .scan_q(obj_scan)
    );

    gfx_irq u_irq (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .LVBL(LVBL), .LHBL(LHBL),
        .irq_en(irq_en), .nmi_en(nmi_en), .vdump(vdump),
        .cpu_irqn(cpu_irqn), .cpu_nmin(cpu_nmin)
    );

    gfx_rom_arbiter u_rom_arbiter (
        .clk(clk), .rst(rst), .gfx_en(gfx_en), .scr_cs(scr_cs), .obj_cs(obj_cs),
        .scr_addr(scr_addr), .obj_addr(obj_addr), .rom_data(rom_data),
        .rom_ok(rom_ok), .scr_data(scr_data), .obj_data(obj_data),
        .scr_ok(scr_ok), .obj_ok(obj_ok), .rom_cs(rom_cs),
        .rom_obj_sel(rom_obj_sel), .rom_addr(rom_addr)
    );

endmodule

// File: tb_gfx_tasks.svh
`ifndef TB_GFX_TASKS_SVH
`define TB_GFX_TASKS_SVH

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic draw_bits(inout logic [31:0] state, input int count,
                         output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
        state = lfsr_next(state);
        value = {value[30:0], state[0]};
    end
endtask

task automatic compare_byte(input gfx_pkg::byte_t got, input gfx_pkg::byte_t exp,
                            input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("Error at %0d ns: %s got %02h expected %02h", $time, what, got, exp);
    end
endtask

task automatic compare_rom_data(input gfx_pkg::rom_data_t got,
                                input gfx_pkg::rom_data_t exp, input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("Error at %0d ns: %s got %04h expected %04h", $time, what, got, exp);
    end
endtask

task automatic compare_rom_addr(input gfx_pkg::rom_addr_t got,
                                input gfx_pkg::rom_addr_t exp, input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("Error at %0d ns: %s got %05h expected %05h", $time, what, got, exp);
    end
endtask

task automatic compare_bit(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("Error at %0d ns: %s got %b expected %b", $time, what, got, exp);
    end
endtask

task automatic write_bus(input gfx_pkg::cpu_addr_t a, input gfx_pkg::byte_t d);
    @(posedge clk);
    #2;
    addr     = a;
    cpu_dout = d;
    cpu_rnw  = 1'b0;
    cs       = 1'b1;
    @(posedge clk);
    #2;
    cs      = 1'b0;
    cpu_rnw = 1'b1;
endtask

// RAM data is ready from the second edge after the address
task automatic read_bus(input gfx_pkg::cpu_addr_t a, output gfx_pkg::byte_t d);
    @(posedge clk);
    #2;
    addr    = a;
    cpu_rnw = 1'b1;
    cs      = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    d = dout;
    @(posedge clk);
    #2;
    cs = 1'b0;
endtask

task automatic wait_interrupt(input logic nmi, input logic level, input string what);
    logic seen;
    seen = 1'b0;
    for (int i = 0; i < WAIT_LIMIT && !seen; i++) begin
        @(negedge clk);
        seen = ((nmi ? cpu_nmin : cpu_irqn) === level);
    end
    if (!seen) begin
        error_count++;
        $display("Timed out at %0d ns waiting for %s", $time, what);
    end
endtask

// Client drops its cs in the cycle its ok shows up
task automatic await_ok(input logic obj, output logic sel_seen,
                        output gfx_pkg::rom_addr_t addr_seen);
    logic seen;
    seen      = 1'b0;
    sel_seen  = 1'b0;
    addr_seen = '0;
    for (int i = 0; i < WAIT_LIMIT && !seen; i++) begin
        @(posedge clk);
        #2;
        if (rom_cs && rom_obj_sel) begin
            sel_seen = 1'b1;
        end
        if (rom_cs) begin
            addr_seen = rom_addr;
        end
        seen = obj ? obj_ok : scr_ok;
    end
    if (obj) begin
        obj_cs = 1'b0;
    end else begin
        scr_cs = 1'b0;
    end
    if (!seen) begin
        error_count++;
        $display("Timed out at %0d ns waiting for %s", $time, obj ? "obj_ok" : "scr_ok");
    end
endtask

task automatic register_readback();
    gfx_pkg::byte_t     value;
    gfx_pkg::byte_t     written [0:8];
    gfx_pkg::cpu_addr_t reg_addr;
    logic [31:0]        bits;
    for (int r = 0; r < 8; r++) begin
        read_bus(gfx_pkg::cpu_addr_t'(r), value);
        compare_byte(value, 8'h00, $sformatf("register %0d after reset", r));
    end
    read_bus(14'd8, value);
    compare_byte(value, 8'hff, "register 8 after reset");
    // Entry 8 of the list stands for register 30
    for (int r = 0; r < 9; r++) begin
        reg_addr = (r == 8) ? 14'd30 : gfx_pkg::cpu_addr_t'(r);
        draw_bits(data_lfsr, 8, bits);
        written[r] = bits[7:0];
        write_bus(reg_addr, written[r]);
    end
    for (int r = 0; r < 9; r++) begin
        reg_addr = (r == 8) ? 14'd30 : gfx_pkg::cpu_addr_t'(r);
        read_bus(reg_addr, value);
        compare_byte(value, written[r], $sformatf("register %0d readback", reg_addr));
    end
    write_bus(gfx_pkg::cpu_addr_t'(`GFX_REG_CTRL), 8'h00);
    @(negedge clk);
    compare_bit(flip, 1'b0, "flip output cleared");
    write_bus(gfx_pkg::cpu_addr_t'(`GFX_REG_CTRL), gfx_pkg::byte_t'(1 << `GFX_BIT_FLIP));
    @(negedge clk);
    compare_bit(flip, 1'b1, "flip output");
endtask

task automatic video_ram_access();
    logic [31:0]         bits;
    gfx_pkg::tile_addr_t tile;
    gfx_pkg::obj_scan_t  idx;
    gfx_pkg::byte_t      attr_val;
    gfx_pkg::byte_t      code_val;
    gfx_pkg::byte_t      value;
    gfx_pkg::byte_t      page_val [0:1];
    gfx_pkg::cpu_addr_t  attr_addr;
    gfx_pkg::cpu_addr_t  obj_cpu;
    for (int n = 0; n < 4; n++) begin
        draw_bits(data_lfsr, 11, bits);
        tile = bits[10:0];
        draw_bits(data_lfsr, 16, bits);
        attr_val = bits[7:0];
        code_val = bits[15:8];
        // Tile bit 10 sits at address bit 11 and bit 10 picks code RAM
        attr_addr = {2'b10, tile[10], 1'b0, tile[9:0]};
        write_bus(attr_addr, attr_val);
        write_bus(attr_addr | 14'h0400, code_val);
        read_bus(attr_addr, value);
        compare_byte(value, attr_val, "attribute RAM readback");
        read_bus(attr_addr | 14'h0400, value);
        compare_byte(value, code_val, "code RAM readback");
        @(posedge clk);
        #2;
        tile_scan_addr = tile;
        @(posedge clk);
        @(negedge clk);
        compare_byte(attr_scan, attr_val, "attr_scan");
        compare_byte(code_scan, code_val, "code_scan");
    end
    draw_bits(data_lfsr, 18, bits);
    idx         = bits[9:0];
    page_val[0] = bits[17:10];
    page_val[1] = ~bits[17:10];
    for (int p = 0; p < 2; p++) begin
        obj_cpu = {2'b11, p[0], 1'b0, idx};
        write_bus(obj_cpu, page_val[p]);
        read_bus(obj_cpu, value);
        compare_byte(value, page_val[p], "object RAM readback");
    end
    for (int p = 0; p < 2; p++) begin
        write_bus(gfx_pkg::cpu_addr_t'(`GFX_REG_PAGE),
                  gfx_pkg::byte_t'(p << `GFX_BIT_OBJ_PAGE));
        @(posedge clk);
        #2;
        obj_scan_addr = idx;
        @(posedge clk);
        @(negedge clk);
        compare_byte(obj_scan, page_val[p], $sformatf("obj_scan on page %0d", p));
    end
endtask

task automatic vblank_irq();
    logic stayed_high;
    write_bus(gfx_pkg::cpu_addr_t'(`GFX_REG_CTRL), gfx_pkg::byte_t'(1 << `GFX_BIT_IRQ_EN));
    repeat (4) @(posedge clk);
    #2;
    LHBL = 1'b0;
    LVBL = 1'b0;
    wait_interrupt(1'b0, 1'b0, "cpu_irqn low at vblank");
    repeat (4) @(negedge clk);
    compare_bit(cpu_irqn, 1'b0, "cpu_irqn held while LHBL low");
    @(posedge clk);
    #2;
    LHBL = 1'b1;
    wait_interrupt(1'b0, 1'b1, "cpu_irqn release after LHBL");
    @(posedge clk);
    #2;
    LVBL = 1'b1;

    write_bus(gfx_pkg::cpu_addr_t'(`GFX_REG_CTRL), 8'h00);
    repeat (4) @(posedge clk);
    #2;
    LHBL = 1'b0;
    LVBL = 1'b0;
    stayed_high = 1'b1;
    repeat (8) begin
        @(negedge clk);
        if (cpu_irqn !== 1'b1) begin
            stayed_high = 1'b0;
        end
    end
    compare_bit(stayed_high, 1'b1, "cpu_irqn with irq_en clear");
    @(posedge clk);
    #2;
    LHBL = 1'b1;
    LVBL = 1'b1;
endtask

task automatic line_nmi();
    gfx_pkg::vpos_t steps [0:3];
    logic           levels [0:3];
    steps  = '{9'd47, 9'd48, 9'd50, 9'd64};
    levels = '{1'b1, 1'b0, 1'b0, 1'b1};
    write_bus(gfx_pkg::cpu_addr_t'(`GFX_REG_CTRL), gfx_pkg::byte_t'(1 << `GFX_BIT_NMI_EN));
    for (int s = 0; s < 4; s++) begin
        @(posedge clk);
        #2;
        vdump = steps[s];
        wait_interrupt(1'b1, levels[s], $sformatf("cpu_nmin at line %0d", steps[s]));
        repeat (4) @(negedge clk);
        compare_bit(cpu_nmin, levels[s], $sformatf("cpu_nmin at line %0d", steps[s]));
    end
    write_bus(gfx_pkg::cpu_addr_t'(`GFX_REG_CTRL), 8'h00);
    @(posedge clk);
    #2;
    vdump = 9'd48;
    repeat (6) @(negedge clk);
    compare_bit(cpu_nmin, 1'b1, "cpu_nmin with nmi_en clear");
    @(posedge clk);
    #2;
    vdump = '0;
endtask

task automatic rom_arbitration();
    logic [31:0]        bits;
    gfx_pkg::rom_addr_t saddr;
    gfx_pkg::rom_addr_t oaddr;
    gfx_pkg::rom_addr_t addr_seen;
    logic               sel_seen;
    draw_bits(data_lfsr, 18, bits);
    saddr = bits[17:0];
    draw_bits(data_lfsr, 18, bits);
    oaddr = bits[17:0];
    @(posedge clk);
    #2;
    gfx_en   = 2'b11;
    scr_addr = saddr;
    obj_addr = oaddr;
    scr_cs   = 1'b1;
    obj_cs   = 1'b1;
    await_ok(1'b0, sel_seen, addr_seen);
    compare_bit(obj_ok, 1'b0, "obj_ok while scroll completes");
    compare_rom_addr(addr_seen, saddr, "scroll ROM address");
    compare_rom_data(scr_data, saddr[15:0] ^ 16'h5a5a, "scroll ROM data");
    await_ok(1'b1, sel_seen, addr_seen);
    compare_bit(sel_seen, 1'b1, "rom_obj_sel during object access");
    compare_rom_addr(addr_seen, oaddr, "object ROM address");
    compare_rom_data(obj_data, oaddr[15:0] ^ 16'h5a5a, "object ROM data");
endtask

task automatic client_disable();
    logic [31:0]        bits;
    gfx_pkg::rom_addr_t saddr;
    gfx_pkg::rom_addr_t addr_seen;
    logic               granted;
    logic               sel_seen;
    draw_bits(data_lfsr, 18, bits);
    saddr = bits[17:0];
    @(posedge clk);
    #2;
    gfx_en   = 2'b01;
    obj_addr = ~saddr;
    obj_cs   = 1'b1;
    granted  = 1'b0;
    repeat (10) begin
        @(posedge clk);
        #2;
        if (rom_cs || rom_obj_sel) begin
            granted = 1'b1;
        end
    end
    compare_bit(granted, 1'b0, "ROM grant to disabled object client");
    scr_addr = saddr;
    scr_cs   = 1'b1;
    await_ok(1'b0, sel_seen, addr_seen);
    compare_bit(sel_seen, 1'b0, "rom_obj_sel with object client disabled");
    compare_rom_addr(addr_seen, saddr, "scroll ROM address");
    compare_rom_data(scr_data, saddr[15:0] ^ 16'h5a5a, "scroll ROM data");
    compare_bit(obj_ok, 1'b1, "obj_ok released with scroll access");
    compare_rom_data(obj_data, 16'h0000, "disabled object data");
    obj_cs = 1'b0;
    gfx_en = 2'b11;
endtask

`endif

// File: tb_gfx.sv
`timescale 1ns/1ps
`include "gfx_config.svh"

module tb_gfx;

    localparam int          WAIT_LIMIT = 200;
    localparam logic [31:0] LFSR_SEED  = 32'hb563bc19;

    logic                clk;
    logic                rst;
    logic                pxl_cen;
    logic                LHBL;
    logic                LVBL;
    gfx_pkg::vpos_t      vdump;
    logic                cs;
    logic                cpu_rnw;
    logic                cpu_cen;
    gfx_pkg::cpu_addr_t  addr;
    gfx_pkg::byte_t      cpu_dout;
    gfx_pkg::tile_addr_t tile_scan_addr;
    gfx_pkg::obj_scan_t  obj_scan_addr;
    logic [1:0]          gfx_en;
    logic                scr_cs;
    logic                obj_cs;
    gfx_pkg::rom_addr_t  scr_addr;
    gfx_pkg::rom_addr_t  obj_addr;
    gfx_pkg::rom_data_t  rom_data;
    logic                rom_ok;

    gfx_pkg::byte_t      dout;
    logic                cpu_irqn;
    logic                cpu_nmin;
    logic                flip;
    gfx_pkg::byte_t      attr_scan;
    gfx_pkg::byte_t      code_scan;
    gfx_pkg::byte_t      obj_scan;
    gfx_pkg::rom_data_t  scr_data;
    gfx_pkg::rom_data_t  obj_data;
    logic                scr_ok;
    logic                obj_ok;
    logic                rom_cs;
    logic                rom_obj_sel;
    gfx_pkg::rom_addr_t  rom_addr;

    int          error_count;
    int          check_count;
    logic [31:0] data_lfsr;
    logic [31:0] delay_lfsr;
    int          rom_wait;

    `include "tb_gfx_tasks.svh"

    gfx_top gfx_top_inst (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .LHBL(LHBL), .LVBL(LVBL),
        .vdump(vdump), .cs(cs), .cpu_rnw(cpu_rnw), .cpu_cen(cpu_cen), .addr(addr),
        .cpu_dout(cpu_dout), .tile_scan_addr(tile_scan_addr),
        .obj_scan_addr(obj_scan_addr), .gfx_en(gfx_en), .scr_cs(scr_cs),
        .obj_cs(obj_cs), .scr_addr(scr_addr), .obj_addr(obj_addr),
        .rom_data(rom_data), .rom_ok(rom_ok), .dout(dout), .cpu_irqn(cpu_irqn),
        .cpu_nmin(cpu_nmin), .flip(flip), .attr_scan(attr_scan),
        .code_scan(code_scan), .obj_scan(obj_scan), .scr_data(scr_data),
        .obj_data(obj_data), .scr_ok(scr_ok), .obj_ok(obj_ok), .rom_cs(rom_cs),
        .rom_obj_sel(rom_obj_sel), .rom_addr(rom_addr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Pixel enable on every second cycle
    initial begin
        pxl_cen = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            pxl_cen = ~pxl_cen;
        end
    end

    // ROM model answers after 1 to 4 cycles
    initial begin
        logic [31:0] bits;
        rom_ok     = 1'b0;
        rom_data   = '0;
        rom_wait   = -1;
        delay_lfsr = LFSR_SEED;
        forever begin
            @(posedge clk);
            #2;
            if (!rom_cs) begin
                rom_ok   = 1'b0;
                rom_wait = -1;
            end else if (!rom_ok) begin
                if (rom_wait < 0) begin
                    draw_bits(delay_lfsr, 2, bits);
                    rom_wait = int'(bits[1:0]) + 1;
                end else begin
                    rom_wait = rom_wait - 1;
                    if (rom_wait == 0) begin
                        rom_ok   = 1'b1;
                        rom_data = rom_addr[15:0] ^ 16'h5a5a;
                    end
                end
            end
        end
    end

    initial begin
        rst            = 1'b1;
        LHBL           = 1'b1;
        LVBL           = 1'b1;
        vdump          = '0;
        cs             = 1'b0;
        cpu_rnw        = 1'b1;
        cpu_cen        = 1'b1;
        addr           = '0;
        cpu_dout       = '0;
        tile_scan_addr = '0;
        obj_scan_addr  = '0;
        gfx_en         = 2'b11;
        scr_cs         = 1'b0;
        obj_cs         = 1'b0;
        scr_addr       = '0;
        obj_addr       = '0;
        error_count    = 0;
        check_count    = 0;
        data_lfsr      = LFSR_SEED;

        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        register_readback();
        video_ram_access();
        vblank_irq();
        line_nmi();
        rom_arbitration();
        client_disable();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+.
gfx_pkg.sv
gfx_regs.sv
gfx_vram.sv
gfx_irq.sv
gfx_rom_arbiter.sv
gfx_top.sv
tb_gfx.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run the testbench, pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_gfx -f build.f || exit 1

sim_out="$(./obj_dir/Vtb_gfx)"
echo "$sim_out"

grep -qx "Testbench passed" <<< "$sim_out" && echo "Result: PASS" || { echo "Result: FAIL"; exit 1; }
